//--- source/ioctl_pkg.sv
//////////////////////////////
// host download types. addresses are absolute byte addresses into the ROM image
//////////////////////////////
`default_nettype none

package ioctl_pkg;

    ////////////////////////////////
    // widths

    // byte address width of the host download stream
    // 25 bits covers a 32 MB image
    localparam int IOCTL_AW = 25;

    ////////////////////////////////
    // host beat

    // one byte as presented by the host
    // wr is a single-cycle strobe and only counts while downloading is high
    typedef struct packed {
        logic [IOCTL_AW-1:0] addr;
        logic [7:0]          data;
        logic                wr;
    } ioctl_beat_t;

endpackage : ioctl_pkg

`default_nettype wire

//--- source/prog_pkg.sv
//////////////////////////////
// program-side request types. mask bits are active low, as on the SDRAM port
//////////////////////////////
`default_nettype none

package prog_pkg;

    ////////////////////////////////
    // widths

    // half-word address width of one SDRAM bank
    localparam int PROG_AW = 22;
    // four banks
    localparam int BANK_W  = 2;

    ////////////////////////////////
    // target word

    // SDRAM view: bank plus half-word address relative to that bank's start
    typedef struct packed {
        logic [BANK_W-1:0]  ba;
        logic [PROG_AW-1:0] addr;
    } sdram_tgt_t;

    // PROM view: plain byte address, pad keeps it the width of the SDRAM view
    typedef struct packed {
        logic [BANK_W-1:0]  pad;
        logic [PROG_AW-1:0] addr;
    } prom_tgt_t;

    // the same target bits are read one way or the other by is_prom
    typedef union packed {
        sdram_tgt_t sdram;
        prom_tgt_t  prom;
    } prog_tgt_u;

    ////////////////////////////////
    // request and port

    // one routed byte
    // mask is 2'b10 for an odd byte, 2'b01 for an even one
    typedef struct packed {
        logic       is_prom;
        prog_tgt_u  tgt;
        logic [7:0] data;
        logic [1:0] mask;
    } prog_req_t;

    // SDRAM write port, we is held until the controller acknowledges
    typedef struct packed {
        logic [PROG_AW-1:0] addr;
        logic [BANK_W-1:0]  ba;
        logic [15:0]        data;
        logic [1:0]         mask;
        logic               we;
    } sdram_wr_t;

endpackage : prog_pkg

`default_nettype wire

//--- source/rom_dwnld_router.sv
//////////////////////////////
// all-ones start values disable PROM or banking. PROM_AW must not exceed PROG_AW
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module rom_dwnld_router
    import ioctl_pkg::*, prog_pkg::*;
#(
    parameter logic [IOCTL_AW-1:0] PROM_START = '1,
    parameter logic [IOCTL_AW-1:0] BA1_START  = '1,
    parameter logic [IOCTL_AW-1:0] BA2_START  = '1,
    parameter logic [IOCTL_AW-1:0] BA3_START  = '1,
    parameter int                  PROM_AW    = 12
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               downloading,
    input  ioctl_beat_t        beat,
    output prog_req_t          req,
    output logic               push,
    output logic               prom_we,
    output logic [PROM_AW-1:0] prom_addr,
    output logic [7:0]         prom_data
);

    // a start value of all ones means the feature is not used
    localparam logic [IOCTL_AW-1:0] ALL_ONES = {IOCTL_AW{1'b1}};
    localparam bit BA_EN   = (BA1_START != ALL_ONES) || (BA2_START != ALL_ONES) ||
                             (BA3_START != ALL_ONES);
    localparam bit PROM_EN = (PROM_START != ALL_ONES);

    logic                accept;
    logic                is_prom;
    logic [BANK_W-1:0]   bank;
    logic [IOCTL_AW-1:0] offset;
    logic [IOCTL_AW-1:0] eff_addr;
    prog_req_t           req_d;

    // a byte only counts while the download window is open
    assign accept  = beat.wr && downloading;
    // everything from PROM_START upwards belongs to the on-chip PROM
    assign is_prom = PROM_EN && (beat.addr >= PROM_START);

    //////////////////////////////
    // bank decode

    // highest bank whose start is at or below the address wins
    always_comb begin
        if (!BA_EN) begin
            bank = 2'd0;
        end else if (beat.addr >= BA3_START) begin
            bank = 2'd3;
        end else if (beat.addr >= BA2_START) begin
            bank = 2'd2;
        end else if (beat.addr >= BA1_START) begin
            bank = 2'd1;
        end else begin
            bank = 2'd0;
        end
        case (bank)
            2'd1:    offset = BA1_START;
            2'd2:    offset = BA2_START;
            2'd3:    offset = BA3_START;
            default: offset = '0;
        endcase
        // byte offset inside the bank, bit 0 becomes the lane select
        eff_addr = beat.addr - offset;
    end

    //////////////////////////////
    // request build

    always_comb begin
        req_d.is_prom = is_prom;
        if (is_prom) begin
            // PROM keeps the absolute byte address, the low bits index the array
            req_d.tgt.prom.pad  = '0;
            req_d.tgt.prom.addr = beat.addr[PROG_AW-1:0];
        end else begin
            req_d.tgt.sdram.ba   = bank;
            req_d.tgt.sdram.addr = eff_addr[PROG_AW:1];
        end
        req_d.data = beat.data;
        // odd bytes go to the lower lane
        req_d.mask = beat.addr[0] ? 2'b10 : 2'b01;
    end

    // strobes are single-cycle, one cycle after the accepting edge
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            push    <= 1'b0;
            prom_we <= 1'b0;
        end else begin
            push    <= accept && !is_prom;
            prom_we <= accept && is_prom;
        end
    end

    // payload is only looked at together with a strobe
    always_ff @(posedge clk) begin
        if (accept) begin
            req <= req_d;
        end
    end

    // PROM side reads the PROM view of the registered target
    assign prom_addr = req.tgt.prom.addr[PROM_AW-1:0];
    assign prom_data = req.data;

endmodule : rom_dwnld_router

`default_nettype wire

//--- source/prog_fifo.sv
//////////////////////////////
// show-ahead FIFO, FIFO_DEPTH a power of two. full also counts a push in flight
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module prog_fifo
    import prog_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      flush,
    input  logic      push,
    input  prog_req_t din,
    input  logic      pop,
    output prog_req_t dout,
    output logic      empty,
    output logic      full
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    prog_req_t        mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             wr_en;
    logic             rd_en;
    logic             at_depth;

    assign at_depth = (count == FIFO_DEPTH[PTR_W:0]);
    assign empty    = (count == '0);

    // the host samples full before it strobes, and the router adds one cycle,
    // so a push already on its way has to be counted as an occupied slot
    assign full = at_depth || ((count == FIFO_DEPTH[PTR_W:0] - 1'b1) && push);

    // a pop frees a slot in the same cycle
    assign wr_en = push && (!at_depth || pop);
    assign rd_en = pop && !empty;

    //////////////////////////////
    // pointers and count

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // simultaneous push and pop leave the count alone
            if (wr_en && !rd_en) begin
                count <= count + 1'b1;
            end else if (!wr_en && rd_en) begin
                count <= count - 1'b1;
            end
        end
    end

    //////////////////////////////
    // storage

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= din;
        end
    end

    // head is presented straight from the array
    assign dout = mem[rd_ptr];

endmodule : prog_fifo

`default_nettype wire

//--- source/sdram_prog_writer.sv
//////////////////////////////
// one write in flight. only SDRAM requests reach this block
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module sdram_prog_writer
    import prog_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      downloading,
    input  prog_req_t head,
    input  logic      empty,
    output logic      pop,
    output sdram_wr_t sdram,
    input  logic      sdram_ack
);

    typedef enum logic {
        ST_IDLE,
        ST_WRITE
    } state_t;

    state_t             state;
    logic               start;
    logic [PROG_AW-1:0] addr_q;
    logic [BANK_W-1:0]  ba_q;
    logic [7:0]         data_q;
    logic [1:0]         mask_q;

    // a valid head is taken on the next edge when idle
    assign start = (state == ST_IDLE) && !empty && downloading;

    // the entry leaves the FIFO on the edge where the ack is seen
    assign pop = (state == ST_WRITE) && sdram_ack && downloading;

    //////////////////////////////
    // control

    // we is the write state itself, so it drops on the edge after ack
    // and stays low for one cycle before the next entry is taken
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else if (!downloading) begin
            // end of download abandons the write, the FIFO is flushed too
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (!empty) begin
                        state <= ST_WRITE;
                    end
                end
                ST_WRITE: begin
                    if (sdram_ack) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    //////////////////////////////
    // payload

    // head is read through the SDRAM view of the target union
    always_ff @(posedge clk) begin
        if (start) begin
            addr_q <= head.tgt.sdram.addr;
            ba_q   <= head.tgt.sdram.ba;
            data_q <= head.data;
            mask_q <= head.mask;
        end
    end

    // the byte goes out on both lanes, the mask picks the one written
    always_comb begin
        sdram.addr = addr_q;
        sdram.ba   = ba_q;
        sdram.data = {data_q, data_q};
        sdram.mask = mask_q;
        sdram.we   = (state == ST_WRITE);
    end

endmodule : sdram_prog_writer

`default_nettype wire

//--- source/prom_mem.sv
//////////////////////////////
// 2**PROM_AW bytes, contents undefined until written
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module prom_mem #(
    parameter int PROM_AW = 12
) (
    input  logic               clk,
    input  logic               we,
    input  logic [PROM_AW-1:0] waddr,
    input  logic [7:0]         wdata,
    input  logic [PROM_AW-1:0] raddr,
    output logic [7:0]         rdata
);

    localparam int DEPTH = 2 ** PROM_AW;

    logic [7:0] mem [DEPTH];

    //////////////////////////////
    // write port

    // the router drives this during download only
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    //////////////////////////////
    // read port

    // registered read so the array maps onto block RAM
    // rdata follows raddr by one cycle
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule : prom_mem

`default_nettype wire

//--- source/rom_dwnld_top.sv
//////////////////////////////
// host must hold wr low while busy is high. all-ones starts disable PROM or banks
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module rom_dwnld_top
    import ioctl_pkg::*, prog_pkg::*;
#(
    parameter logic [IOCTL_AW-1:0] PROM_START = '1,
    parameter logic [IOCTL_AW-1:0] BA1_START  = '1,
    parameter logic [IOCTL_AW-1:0] BA2_START  = '1,
    parameter logic [IOCTL_AW-1:0] BA3_START  = '1,
    parameter int                  FIFO_DEPTH = 4,
    parameter int                  PROM_AW    = 12
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               downloading,
    input  ioctl_beat_t        beat,
    output logic               busy,
    output sdram_wr_t          sdram,
    input  logic               sdram_ack,
    input  logic [PROM_AW-1:0] prom_raddr,
    output logic [7:0]         prom_rdata
);

    // router to FIFO
    prog_req_t          rt_req;
    logic               rt_push;
    // router to PROM
    logic               rt_prom_we;
    logic [PROM_AW-1:0] rt_prom_addr;
    logic [7:0]         rt_prom_data;
    // FIFO to writer
    prog_req_t          fifo_head;
    logic               fifo_empty;
    logic               wr_pop;

    //////////////////////////////
    // byte classification

    rom_dwnld_router #(
        .PROM_START (PROM_START),
        .BA1_START  (BA1_START),
        .BA2_START  (BA2_START),
        .BA3_START  (BA3_START),
        .PROM_AW    (PROM_AW)
    ) u_router (
        .clk         (clk),
        .rst_n       (rst_n),
        .downloading (downloading),
        .beat        (beat),
        .req         (rt_req),
        .push        (rt_push),
        .prom_we     (rt_prom_we),
        .prom_addr   (rt_prom_addr),
        .prom_data   (rt_prom_data)
    );

    //////////////////////////////
    // SDRAM path

    // leftovers are dropped as soon as the download window closes
    prog_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .flush (!downloading),
        .push  (rt_push),
        .din   (rt_req),
        .pop   (wr_pop),
        .dout  (fifo_head),
        .empty (fifo_empty),
        .full  (busy)
    );

    sdram_prog_writer u_writer (
        .clk         (clk),
        .rst_n       (rst_n),
        .downloading (downloading),
        .head        (fifo_head),
        .empty       (fifo_empty),
        .pop         (wr_pop),
        .sdram       (sdram),
        .sdram_ack   (sdram_ack)
    );

    //////////////////////////////
    // PROM side sink

    prom_mem #(
        .PROM_AW (PROM_AW)
    ) u_prom (
        .clk   (clk),
        .we    (rt_prom_we),
        .waddr (rt_prom_addr),
        .wdata (rt_prom_data),
        .raddr (prom_raddr),
        .rdata (prom_rdata)
    );

endmodule : rom_dwnld_top

`default_nettype wire

//--- bench/rom_dwnld_tb.sv
//////////////////////////////
// random download stream from a fixed LFSR seed, SDRAM acked by a model
// stops at the first mismatch. PROM readback covers written addresses only
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module rom_dwnld_tb
    import ioctl_pkg::*, prog_pkg::*;
();

    localparam logic [IOCTL_AW-1:0] PROM_START = 25'h1F000;
    localparam logic [IOCTL_AW-1:0] BA1_START  = 25'h4000;
    localparam logic [IOCTL_AW-1:0] BA2_START  = 25'h8000;
    localparam logic [IOCTL_AW-1:0] BA3_START  = 25'h10000;
    localparam int                  FIFO_DEPTH = 4;
    localparam int                  PROM_AW    = 12;

    // beats per test phase
    localparam int N_MAIN  = 120;
    localparam int N_BURST = 40;
    localparam int N_IGN   = 16;
    localparam int N_ABORT = 12;
    localparam int N_AFTER = 40;
    localparam int TOTAL_BEATS = N_MAIN + N_BURST + N_IGN + N_ABORT + N_AFTER;
    // worst beat is a 3 cycle gap plus a write held for 7 cycles of ack delay
    localparam int CYCLE_LIMIT = TOTAL_BEATS * 12 + 200;

    logic               clk;
    logic               rst_n;
    logic               downloading;
    ioctl_beat_t        beat;
    logic               busy;
    sdram_wr_t          sdram;
    logic               sdram_ack;
    logic [PROM_AW-1:0] prom_raddr;
    logic [7:0]         prom_rdata;

    logic [31:0]        lfsr;
    int                 cycle_count;
    int                 ack_delay;
    bit                 saw_busy;
    // SDRAM writes still owed by the DUT, oldest first
    sdram_wr_t          expected_q [$];
    // shadow PROM and the list of addresses that were written
    logic [7:0]         shadow [2**PROM_AW];
    logic [PROM_AW-1:0] prom_addrs [$];

    rom_dwnld_top #(
        .PROM_START (PROM_START),
        .BA1_START  (BA1_START),
        .BA2_START  (BA2_START),
        .BA3_START  (BA3_START),
        .FIFO_DEPTH (FIFO_DEPTH),
        .PROM_AW    (PROM_AW)
    ) uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .downloading (downloading),
        .beat        (beat),
        .busy        (busy),
        .sdram       (sdram),
        .sdram_ack   (sdram_ack),
        .prom_raddr  (prom_raddr),
        .prom_rdata  (prom_rdata)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    //////////////////////////////
    // reporting

    task automatic stop_run();
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic fail_run(input string msg);
        $display("%s", msg);
        stop_run();
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] got);
        if (expected !== got) begin
            $display("FAILED %s expected %h got %h", name, expected, got);
            stop_run();
        end
    endtask

    //////////////////////////////
    // random numbers

    // taps 32 22 2 1 give a maximal length sequence
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one LFSR step per bit handed out
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // picks a bank region, or now and then the PROM range
    function automatic logic [IOCTL_AW-1:0] random_addr(input bit sdram_only);
        logic [1:0]          sel;
        logic [IOCTL_AW-1:0] a;
        sel = 2'(rand_bits(2));
        case (sel)
            2'd0:    a = IOCTL_AW'(rand_bits(14));
            2'd1:    a = BA1_START + IOCTL_AW'(rand_bits(14));
            2'd2:    a = BA2_START + IOCTL_AW'(rand_bits(15));
            default: begin
                if (sdram_only || rand_bits(1) == 32'd0) begin
                    a = BA3_START + IOCTL_AW'(rand_bits(15));
                end else begin
                    // 64 PROM addresses so that overwrites happen often
                    a = PROM_START + IOCTL_AW'(12'(rand_bits(12)) & 12'hE07);
                end
            end
        endcase
        return a;
    endfunction

    //////////////////////////////
    // routing model

    // bank is the highest start not above the byte, address is half-words from it
    function automatic sdram_wr_t route_sdram(input logic [IOCTL_AW-1:0] addr,
                                              input logic [7:0] data);
        sdram_wr_t           wr;
        logic [IOCTL_AW-1:0] start;
        logic [IOCTL_AW-1:0] half;
        if (addr >= BA3_START) begin
            wr.ba = 2'd3;
            start = BA3_START;
        end else if (addr >= BA2_START) begin
            wr.ba = 2'd2;
            start = BA2_START;
        end else if (addr >= BA1_START) begin
            wr.ba = 2'd1;
            start = BA1_START;
        end else begin
            wr.ba = 2'd0;
            start = '0;
        end
        half    = (addr - start) >> 1;
        wr.addr = half[PROG_AW-1:0];
        wr.data = {data, data};
        // active low lane enables, odd bytes sit in the lower lane
        wr.mask = addr[0] ? 2'b10 : 2'b01;
        wr.we   = 1'b1;
        return wr;
    endfunction

    task automatic record_beat(input logic [IOCTL_AW-1:0] addr, input logic [7:0] data);
        if (addr >= PROM_START) begin
            shadow[addr[PROM_AW-1:0]] = data;
            prom_addrs.push_back(addr[PROM_AW-1:0]);
        end else begin
            expected_q.push_back(route_sdram(addr, data));
        end
    endtask

    //////////////////////////////
    // clock step and SDRAM model

    // every wait goes through here so the cycle limit always applies
    task automatic tick();
        sdram_wr_t exp_wr;
        @(negedge clk);
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            fail_run("timeout: the download stream did not finish within the cycle limit");
        end
        // out of reset, a closed download window never shows a write
        if (rst_n && !downloading) begin
            check_value("sdram.we", 32'(1'b0), 32'(sdram.we));
        end
        if (sdram_ack) begin
            // the write was taken on the last rising edge and we must now be low
            sdram_ack = 1'b0;
            check_value("sdram.we", 32'(1'b0), 32'(sdram.we));
        end else if (sdram.we) begin
            if (ack_delay < 0) begin
                ack_delay = int'(rand_bits(3));
            end
            if (ack_delay == 0) begin
                if (expected_q.size() == 0) begin
                    fail_run("SDRAM write seen while no byte was pending");
                end
                exp_wr = expected_q.pop_front();
                check_value("sdram.ba", 32'(exp_wr.ba), 32'(sdram.ba));
                check_value("sdram.addr", 32'(exp_wr.addr), 32'(sdram.addr));
                check_value("sdram.data", 32'(exp_wr.data), 32'(sdram.data));
                check_value("sdram.mask", 32'(exp_wr.mask), 32'(sdram.mask));
                sdram_ack = 1'b1;
                ack_delay = -1;
            end else begin
                ack_delay--;
            end
        end
    endtask

    //////////////////////////////
    // host side

    // one wr strobe, held back while the FIFO is full
    task automatic send_beat(input logic [IOCTL_AW-1:0] addr, input logic [7:0] data);
        while (busy) begin
            saw_busy = 1'b1;
            tick();
        end
        beat.addr = addr;
        beat.data = data;
        beat.wr   = 1'b1;
        if (downloading) begin
            record_beat(addr, data);
        end
        tick();
        beat.wr = 1'b0;
    endtask

    task automatic run_stream(input int count, input bit sdram_only, input bit no_gaps);
        int                  i;
        int                  gap;
        logic [IOCTL_AW-1:0] addr;
        logic [7:0]          data;
        for (i = 0; i < count; i++) begin
            addr = random_addr(sdram_only);
            data = 8'(rand_bits(8));
            send_beat(addr, data);
            gap = no_gaps ? 0 : int'(rand_bits(2));
            repeat (gap) tick();
        end
    endtask

    // waits out the queued writes, then watches for stray ones
    task automatic drain();
        while (expected_q.size() != 0 || sdram.we || sdram_ack) begin
            tick();
        end
        repeat (12) tick();
    endtask

    // strobes with the window closed, half of them aim at PROM bytes already written
    task automatic ignored_beats(input int count);
        int                  i;
        int                  pick;
        logic [PROM_AW-1:0]  low;
        logic [IOCTL_AW-1:0] addr;
        logic [7:0]          data;
        for (i = 0; i < count; i++) begin
            if ((i % 2) == 1 && prom_addrs.size() != 0) begin
                pick = int'(rand_bits(6)) % prom_addrs.size();
                low  = prom_addrs[pick];
                addr = PROM_START + IOCTL_AW'(low);
                data = ~shadow[low];
            end else begin
                addr = random_addr(1'b0);
                data = 8'(rand_bits(8));
            end
            send_beat(addr, data);
            tick();
        end
    endtask

    // closes the window while a write is on the bus, queued bytes are lost
    task automatic abort_burst();
        run_stream(N_ABORT, 1'b1, 1'b1);
        while (!sdram.we) begin
            tick();
        end
        downloading = 1'b0;
        sdram_ack   = 1'b0;
        ack_delay   = -1;
        expected_q.delete();
        tick();
        check_value("busy", 32'(1'b0), 32'(busy));
        repeat (4) tick();
        downloading = 1'b1;
    endtask

    // rdata follows raddr by one edge
    task automatic read_prom();
        int i;
        for (i = 0; i < prom_addrs.size(); i++) begin
            prom_raddr = prom_addrs[i];
            tick();
            check_value("prom_rdata", 32'(shadow[prom_addrs[i]]), 32'(prom_rdata));
        end
    endtask

    //////////////////////////////
    // test sequence

    initial begin
        rst_n       = 1'b0;
        downloading = 1'b0;
        beat        = '0;
        sdram_ack   = 1'b0;
        prom_raddr  = '0;
        lfsr        = 32'h8cef_d991;
        cycle_count = 0;
        ack_delay   = -1;
        saw_busy    = 1'b0;

        repeat (8) tick();
        rst_n = 1'b1;
        check_value("busy", 32'(1'b0), 32'(busy));
        check_value("sdram.we", 32'(1'b0), 32'(sdram.we));

        // mixed stream with gaps over all banks and the PROM range
        downloading = 1'b1;
        run_stream(N_MAIN, 1'b0, 1'b0);
        // back to back beats outrun the acks and fill the FIFO
        saw_busy = 1'b0;
        run_stream(N_BURST, 1'b0, 1'b1);
        check_value("busy", 32'(1'b1), 32'(saw_busy));
        drain();

        // nothing may land while the window is closed
        downloading = 1'b0;
        ignored_beats(N_IGN);
        repeat (12) tick();

        downloading = 1'b1;
        abort_burst();
        run_stream(N_AFTER, 1'b0, 1'b0);
        drain();

        read_prom();
        $display("Regression passed");
        $finish;
    end

endmodule : rom_dwnld_tb

`default_nettype wire

//--- dwnld_sys.f
source/ioctl_pkg.sv
source/prog_pkg.sv
source/rom_dwnld_router.sv
source/prog_fifo.sv
source/sdram_prog_writer.sv
source/prom_mem.sv
source/rom_dwnld_top.sv
bench/rom_dwnld_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the ROM download testbench with Verilator and runs it
# the run counts as good only when the pass line shows up in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f dwnld_sys.f --top-module rom_dwnld_tb -Mdir obj_dir \
    && ./obj_dir/Vrom_dwnld_tb | tee /dev/stderr | grep -q "Regression passed" \
    && echo "simulation finished cleanly" \
    || { echo "simulation reported a problem" >&2; exit 1; }
